// ==== hdl/cpu_cfg.svh ====
/*
 * serial cpu configuration
 * word, bus and address widths, register count and start address
 */
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

// register and instruction width
`define CPU_WORD_W   16
// memory bus is one byte wide
`define CPU_BYTE_W   8
// word address, byte select is appended below it
`define CPU_PC_W     8
// general register count
`define CPU_GR_NUM   4
// first instruction word, i.e. byte 32
`define CPU_PC_START 16

`endif

// ==== hdl/cpu_pkg.sv ====
/*
 * serial cpu package
 * word types, opcode and state enums, instruction fields and opcode classes
 */
`include "cpu_cfg.svh"

package cpu_pkg;

    typedef logic [`CPU_WORD_W-1:0] word_t;
    typedef logic [`CPU_BYTE_W-1:0] byte_t;
    typedef logic [`CPU_PC_W-1:0]   pc_t;
    // word address plus byte select in bit 0
    typedef logic [`CPU_PC_W:0]     mem_addr_t;
    // only the low two bits pick a register
    typedef logic [2:0]             gr_idx_t;

    typedef enum logic [4:0] {
        NOP   = 5'd0,
        HALT  = 5'd1,
        LOAD  = 5'd2,
        STORE = 5'd3,
        LIOA  = 5'd4,
        LIOB  = 5'd5,
        LIOS  = 5'd6,
        SET   = 5'd7,
        ADD   = 5'd8,
        ADDI  = 5'd9,
        SUB   = 5'd12,
        SUBI  = 5'd13,
        CMP   = 5'd15,
        LDIH  = 5'd16,
        AND   = 5'd17,
        OR    = 5'd18,
        XOR   = 5'd19,
        JUMP  = 5'd24,
        BZ    = 5'd26,
        BNZ   = 5'd27,
        BC    = 5'd30,
        BNC   = 5'd31
    } opcode_e;

    typedef enum logic [2:0] {
        IDLE, IF_LO, IF_HI, ID, EX, MEM_LO, MEM_HI, WB
    } cpu_state_e;

    // operand b source
    typedef enum logic [2:0] {
        B_ZERO, B_R3, B_VAL3, B_IMM8, B_IMM8_HI
    } b_kind_e;

    // imm8 doubles as r2 [6:4], val3 [3:0], r3 [2:0]
    typedef struct packed {
        opcode_e op;
        gr_idx_t r1;
        byte_t   imm8;
    } instr_t;

    typedef struct packed {
        word_t reg_a;
        word_t reg_b;
        word_t smdr;
    } operands_t;

    typedef struct packed {
        logic zf;
        logic cf;
    } flags_t;

    // -------------------------------------------------------------------
    // opcode classes
    // -------------------------------------------------------------------

    function automatic logic writes_flags(opcode_e op);
        return op inside {ADD, SUB, CMP, AND, OR, XOR, ADDI, SUBI, LDIH};
    endfunction

    // result written in WB, load bytes go in separately
    function automatic logic writes_reg(opcode_e op);
        return op inside {ADD, SUB, AND, OR, XOR, ADDI, SUBI, LDIH, SET,
                          LIOA, LIOB, LIOS};
    endfunction

    function automatic logic a_from_r1(opcode_e op);
        return op inside {ADDI, SUBI, LDIH, BZ, BNZ, BC, BNC};
    endfunction

    function automatic logic a_from_r2(opcode_e op);
        return op inside {ADD, SUB, CMP, AND, OR, XOR, LOAD, STORE};
    endfunction

    function automatic b_kind_e b_kind(opcode_e op);
        b_kind_e k;
        case (op)
            ADD, SUB, CMP, AND, OR, XOR:          k = B_R3;
            LOAD, STORE:                          k = B_VAL3;
            ADDI, SUBI, SET, JUMP, BZ, BNZ, BC, BNC: k = B_IMM8;
            LDIH:                                 k = B_IMM8_HI;
            default:                              k = B_ZERO;
        endcase
        return k;
    endfunction

endpackage

// ==== hdl/cpu_sequencer.sv ====
/*
 * cpu sequencer: eight-state FSM, program counter and two-byte fetch
 */
`timescale 1ns/1ns
`include "cpu_cfg.svh"

module cpu_sequencer (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                start,
    input  cpu_pkg::byte_t      i_datain,
    input  logic                branch_taken,
    input  cpu_pkg::pc_t        target,
    output cpu_pkg::cpu_state_e state,
    output cpu_pkg::instr_t     ir,
    output cpu_pkg::mem_addr_t  i_addr,
    output logic                is_i_addr,
    output logic                done
);

    cpu_pkg::cpu_state_e next_state;
    cpu_pkg::pc_t        pc;
    logic                instr_over;

    // last word of program space
    assign instr_over = (pc == '1);

    // -------------------------------------------------------------------
    // state machine
    // -------------------------------------------------------------------
    always_comb
    begin
        case (state)
            cpu_pkg::IDLE:   next_state = start ? cpu_pkg::IF_LO : cpu_pkg::IDLE;
            cpu_pkg::IF_LO:  next_state = cpu_pkg::IF_HI;
            cpu_pkg::IF_HI:  next_state = cpu_pkg::ID;
            cpu_pkg::ID:     next_state = cpu_pkg::EX;
            cpu_pkg::EX:     next_state = cpu_pkg::MEM_LO;
            cpu_pkg::MEM_LO: next_state = cpu_pkg::MEM_HI;
            cpu_pkg::MEM_HI: next_state = cpu_pkg::WB;
            cpu_pkg::WB:
                // stop on halt or at the end of program space
                if (ir.op == cpu_pkg::HALT || instr_over)
                    next_state = cpu_pkg::IDLE;
                else
                    next_state = cpu_pkg::IF_LO;
            default:         next_state = cpu_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state <= cpu_pkg::IDLE;
            done  <= 1'b0;
        end
        else
        begin
            state <= next_state;
            // one cycle pulse right after a halt retires
            done  <= (state == cpu_pkg::WB) && (ir.op == cpu_pkg::HALT);
        end
    end

    // -------------------------------------------------------------------
    // fetch, low byte at the even address first
    // -------------------------------------------------------------------
    assign is_i_addr = (state == cpu_pkg::IF_LO) || (state == cpu_pkg::IF_HI);
    assign i_addr    = {pc, state == cpu_pkg::IF_HI};

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            ir <= '{op: cpu_pkg::NOP, r1: '0, imm8: '0};
        else if (state == cpu_pkg::IF_LO)
            ir <= cpu_pkg::instr_t'({ir[`CPU_WORD_W-1:`CPU_BYTE_W], i_datain});
        else if (state == cpu_pkg::IF_HI)
            ir <= cpu_pkg::instr_t'({i_datain, ir.imm8});
    end

    // pc moves once per instruction, at the end of WB
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            pc <= cpu_pkg::pc_t'(`CPU_PC_START);
        else if (state == cpu_pkg::WB)
        begin
            if (branch_taken)
                pc <= target;
            else if (instr_over)
                pc <= cpu_pkg::pc_t'(`CPU_PC_START);
            else
                pc <= pc + 1'b1;
        end
    end

    // fetch window is IF_LO then IF_HI, never longer
    a_fetch_window: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(is_i_addr) |-> state == cpu_pkg::IF_LO
            ##1 (is_i_addr && state == cpu_pkg::IF_HI) ##1 !is_i_addr);

    // done lands in IDLE and drops again
    a_done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        done |-> state == cpu_pkg::IDLE ##1 !done);

endmodule

// ==== hdl/operand_fetch.sv ====
/*
 * decode stage: latches operand a, operand b and store data in ID
 */
`timescale 1ns/1ns
`include "cpu_cfg.svh"

module operand_fetch (
    input  logic                clk,
    input  logic                rst_n,
    input  cpu_pkg::cpu_state_e state,
    input  cpu_pkg::instr_t     ir,
    input  cpu_pkg::word_t      rd_r1,
    input  cpu_pkg::word_t      rd_r2,
    input  cpu_pkg::word_t      rd_r3,
    output cpu_pkg::operands_t  ops
);

    cpu_pkg::word_t a_next;
    cpu_pkg::word_t b_next;

    // operand a, zero covers JUMP
    always_comb
    begin
        if (cpu_pkg::a_from_r1(ir.op))
            a_next = rd_r1;
        else if (cpu_pkg::a_from_r2(ir.op))
            a_next = rd_r2;
        else
            a_next = '0;
    end

    // operand b from register or immediate field
    always_comb
    begin
        case (cpu_pkg::b_kind(ir.op))
            cpu_pkg::B_R3:      b_next = rd_r3;
            cpu_pkg::B_VAL3:    b_next = {12'h000, ir.imm8[3:0]};
            cpu_pkg::B_IMM8:    b_next = {{`CPU_BYTE_W{1'b0}}, ir.imm8};
            cpu_pkg::B_IMM8_HI: b_next = {ir.imm8, {`CPU_BYTE_W{1'b0}}};
            default:            b_next = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            ops <= '0;
        else if (state == cpu_pkg::ID)
        begin
            ops.reg_a <= a_next;
            ops.reg_b <= b_next;
            // store data always comes from r1
            if (ir.op == cpu_pkg::STORE)
                ops.smdr <= rd_r1;
        end
    end

endmodule

// ==== hdl/exec_unit.sv ====
/*
 * execute unit: ALU, result and flag registers, branch test, data port
 */
`timescale 1ns/1ns
`include "cpu_cfg.svh"

module exec_unit (
    input  logic                clk,
    input  logic                rst_n,
    input  cpu_pkg::cpu_state_e state,
    input  cpu_pkg::instr_t     ir,
    input  cpu_pkg::operands_t  ops,
    input  cpu_pkg::word_t      io_status,
    input  cpu_pkg::word_t      io_data_a,
    input  cpu_pkg::word_t      io_data_b,
    output cpu_pkg::word_t      reg_c,
    output logic                branch_taken,
    output cpu_pkg::pc_t        target,
    output cpu_pkg::mem_addr_t  d_addr,
    output logic                d_we,
    output cpu_pkg::byte_t      d_dataout
);

    cpu_pkg::word_t  alu_res;
    logic            alu_cf;
    cpu_pkg::flags_t flags;
    logic            mem_state;

    // -------------------------------------------------------------------
    // ALU, carry out is the borrow on subtracts
    // -------------------------------------------------------------------
    always_comb
    begin
        case (ir.op)
            cpu_pkg::AND:  {alu_cf, alu_res} = {1'b0, ops.reg_a & ops.reg_b};
            cpu_pkg::OR:   {alu_cf, alu_res} = {1'b0, ops.reg_a | ops.reg_b};
            cpu_pkg::XOR:  {alu_cf, alu_res} = {1'b0, ops.reg_a ^ ops.reg_b};
            cpu_pkg::SET:  {alu_cf, alu_res} = {1'b0, ops.reg_b};
            cpu_pkg::SUB, cpu_pkg::SUBI, cpu_pkg::CMP:
                {alu_cf, alu_res} = {1'b0, ops.reg_a} - {1'b0, ops.reg_b};
            // adds, ldih, memory address and branch target
            default:
                {alu_cf, alu_res} = {1'b0, ops.reg_a} + {1'b0, ops.reg_b};
        endcase
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            reg_c <= '0;
            flags <= '0;
        end
        else if (state == cpu_pkg::EX)
        begin
            case (ir.op)
                cpu_pkg::LIOA: reg_c <= io_data_a;
                cpu_pkg::LIOB: reg_c <= io_data_b;
                cpu_pkg::LIOS: reg_c <= io_status;
                default:       reg_c <= alu_res;
            endcase
            if (cpu_pkg::writes_flags(ir.op))
            begin
                flags.zf <= (alu_res == '0);
                flags.cf <= alu_cf;
            end
        end
    end

    // branch test on flags left by earlier instructions
    always_comb
    begin
        case (ir.op)
            cpu_pkg::JUMP: branch_taken = 1'b1;
            cpu_pkg::BZ:   branch_taken = flags.zf;
            cpu_pkg::BNZ:  branch_taken = !flags.zf;
            cpu_pkg::BC:   branch_taken = flags.cf;
            cpu_pkg::BNC:  branch_taken = !flags.cf;
            default:       branch_taken = 1'b0;
        endcase
    end

    assign target = reg_c[`CPU_PC_W-1:0];

    // -------------------------------------------------------------------
    // data memory, low byte in MEM_LO then high byte in MEM_HI
    // -------------------------------------------------------------------
    assign mem_state = (state == cpu_pkg::MEM_LO) || (state == cpu_pkg::MEM_HI);
    assign d_addr    = {reg_c[`CPU_PC_W-1:0], state == cpu_pkg::MEM_HI};
    assign d_we      = mem_state && (ir.op == cpu_pkg::STORE);
    assign d_dataout = (state == cpu_pkg::MEM_HI) ? ops.smdr[`CPU_WORD_W-1:`CPU_BYTE_W]
                                                  : ops.smdr[`CPU_BYTE_W-1:0];

    // a store writes exactly two bytes, low then high
    a_store_bytes: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(d_we) |-> (state == cpu_pkg::MEM_LO && ir.op == cpu_pkg::STORE)
            ##1 (d_we && state == cpu_pkg::MEM_HI) ##1 !d_we);

endmodule

// ==== hdl/reg_file.sv ====
/*
 * general registers: three read ports, load-byte and result writeback
 */
`timescale 1ns/1ns
`include "cpu_cfg.svh"

module reg_file (
    input  logic                clk,
    input  logic                rst_n,
    input  cpu_pkg::cpu_state_e state,
    input  cpu_pkg::instr_t     ir,
    input  cpu_pkg::word_t      reg_c,
    input  cpu_pkg::byte_t      d_datain,
    output cpu_pkg::word_t      rd_r1,
    output cpu_pkg::word_t      rd_r2,
    output cpu_pkg::word_t      rd_r3,
    output cpu_pkg::word_t      io_control,
    output cpu_pkg::word_t      io_out_a,
    output cpu_pkg::word_t      io_out_b
);

    localparam int GI_W = $clog2(`CPU_GR_NUM);

    cpu_pkg::word_t  gr [`CPU_GR_NUM];
    logic [GI_W-1:0] wr_idx;
    logic            is_load;

    assign wr_idx  = ir.r1[GI_W-1:0];
    assign is_load = (ir.op == cpu_pkg::LOAD);

    // read ports r1, r2 (imm8 [6:4]) and r3 (imm8 [2:0])
    assign rd_r1 = gr[ir.r1[GI_W-1:0]];
    assign rd_r2 = gr[ir.imm8[GI_W+3:4]];
    assign rd_r3 = gr[ir.imm8[GI_W-1:0]];

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < `CPU_GR_NUM; i++)
                gr[i] <= '0;
        end
        else if (state == cpu_pkg::MEM_LO && is_load)
            gr[wr_idx][`CPU_BYTE_W-1:0] <= d_datain;
        else if (state == cpu_pkg::MEM_HI && is_load)
            gr[wr_idx][`CPU_WORD_W-1:`CPU_BYTE_W] <= d_datain;
        else if (state == cpu_pkg::WB && cpu_pkg::writes_reg(ir.op))
            gr[wr_idx] <= reg_c;
    end

    // io views of registers 1 to 3
    assign io_control = gr[1];
    assign io_out_a   = gr[2];
    assign io_out_b   = gr[3];

endmodule

// ==== hdl/serial_cpu.sv ====
/*
 * serial cpu top, 16-bit word on an 8-bit memory bus
 */
`timescale 1ns/1ns

module serial_cpu (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              start,
    input  cpu_pkg::byte_t    i_datain,
    input  cpu_pkg::byte_t    d_datain,
    input  cpu_pkg::word_t    io_status,
    input  cpu_pkg::word_t    io_data_a,
    input  cpu_pkg::word_t    io_data_b,
    output logic              is_i_addr,
    output logic              done,
    output logic              d_we,
    output cpu_pkg::mem_addr_t i_addr,
    output cpu_pkg::mem_addr_t d_addr,
    output cpu_pkg::byte_t    d_dataout,
    output cpu_pkg::word_t    io_control,
    output cpu_pkg::word_t    io_out_a,
    output cpu_pkg::word_t    io_out_b
);

    // shared control from the sequencer
    cpu_pkg::cpu_state_e state;
    cpu_pkg::instr_t     ir;

    // datapath between stages
    cpu_pkg::word_t      rd_r1;
    cpu_pkg::word_t      rd_r2;
    cpu_pkg::word_t      rd_r3;
    cpu_pkg::operands_t  ops;
    cpu_pkg::word_t      reg_c;
    logic                branch_taken;
    cpu_pkg::pc_t        target;

    cpu_sequencer u_cpu_sequencer (
        .clk          (clk),
        .rst_n        (rst_n),
        .start        (start),
        .i_datain     (i_datain),
        .branch_taken (branch_taken),
        .target       (target),
        .state        (state),
        .ir           (ir),
        .i_addr       (i_addr),
        .is_i_addr    (is_i_addr),
        .done         (done)
    );

    operand_fetch u_operand_fetch (
        .clk   (clk),
        .rst_n (rst_n),
        .state (state),
        .ir    (ir),
        .rd_r1 (rd_r1),
        .rd_r2 (rd_r2),
        .rd_r3 (rd_r3),
        .ops   (ops)
    );

    exec_unit u_exec_unit (
        .clk          (clk),
        .rst_n        (rst_n),
        .state        (state),
        .ir           (ir),
        .ops          (ops),
        .io_status    (io_status),
        .io_data_a    (io_data_a),
        .io_data_b    (io_data_b),
        .reg_c        (reg_c),
        .branch_taken (branch_taken),
        .target       (target),
        .d_addr       (d_addr),
        .d_we         (d_we),
        .d_dataout    (d_dataout)
    );

    reg_file u_reg_file (
        .clk        (clk),
        .rst_n      (rst_n),
        .state      (state),
        .ir         (ir),
        .reg_c      (reg_c),
        .d_datain   (d_datain),
        .rd_r1      (rd_r1),
        .rd_r2      (rd_r2),
        .rd_r3      (rd_r3),
        .io_control (io_control),
        .io_out_a   (io_out_a),
        .io_out_b   (io_out_b)
    );

endmodule

// ==== tb/cpu_tests.svh ====
/*
 * directed cpu tests and a small program assembler
 */
`ifndef CPU_TESTS_SVH
`define CPU_TESTS_SVH

// ----------------------------------------------------------------------
// assembler
// ----------------------------------------------------------------------
task automatic emit_instr(cpu_pkg::opcode_e op, int r1, cpu_pkg::byte_t imm8);
    cpu_pkg::instr_t ins;
    ins.op   = op;
    ins.r1   = cpu_pkg::gr_idx_t'(r1);
    ins.imm8 = imm8;
    ld_we    = 1'b1;
    ld_addr  = prog_pc;
    ld_data  = ins;
    @(posedge clk);
    #1;
    ld_we    = 1'b0;
    prog_pc  = prog_pc + 1'b1;
endtask

// r2 sits in imm8 [6:4] and r3 in [2:0]
task automatic alu_rrr(cpu_pkg::opcode_e op, int r1, int r2, int r3);
    emit_instr(op, r1, {1'b0, 3'(r2), 1'b0, 3'(r3)});
endtask

task automatic mem_op(cpu_pkg::opcode_e op, int r1, int r2, logic [3:0] val3);
    emit_instr(op, r1, {1'b0, 3'(r2), val3});
endtask

// SET loads the low byte and LDIH adds the high byte
task automatic load_const(int r, cpu_pkg::word_t v);
    emit_instr(cpu_pkg::SET, r, v[7:0]);
    emit_instr(cpu_pkg::LDIH, r, v[15:8]);
endtask

function automatic logic takes_branch(cpu_pkg::opcode_e op, logic zf, logic cf);
    case (op)
        cpu_pkg::BZ:  return zf;
        cpu_pkg::BNZ: return !zf;
        cpu_pkg::BC:  return cf;
        default:      return !cf;
    endcase
endfunction

// ----------------------------------------------------------------------
// tests
// ----------------------------------------------------------------------
task automatic alu_ops();
    cpu_pkg::word_t a;
    cpu_pkg::word_t b;
    cpu_pkg::word_t r;
    cpu_pkg::byte_t k;
    for (int round = 0; round < 2; round++)
    begin
        a = lcg_next();
        b = lcg_next();
        r = lcg_next();
        k = r[7:0];
        reset_cpu();
        load_const(2, a);
        load_const(3, b);
        // one halt per result so each can be seen on io_control
        alu_rrr(cpu_pkg::ADD, 1, 2, 3);
        emit_instr(cpu_pkg::HALT, 0, 8'h00);
        alu_rrr(cpu_pkg::SUB, 1, 2, 3);
        emit_instr(cpu_pkg::HALT, 0, 8'h00);
        alu_rrr(cpu_pkg::AND, 1, 2, 3);
        emit_instr(cpu_pkg::HALT, 0, 8'h00);
        alu_rrr(cpu_pkg::OR, 1, 2, 3);
        emit_instr(cpu_pkg::HALT, 0, 8'h00);
        alu_rrr(cpu_pkg::XOR, 1, 2, 3);
        emit_instr(cpu_pkg::HALT, 0, 8'h00);
        emit_instr(cpu_pkg::ADDI, 2, k);
        emit_instr(cpu_pkg::SUBI, 3, k);
        emit_instr(cpu_pkg::HALT, 0, 8'h00);
        run_to_halt("alu add");
        check_word("alu add", a + b, io_control);
        check_word("alu setup a", a, io_out_a);
        check_word("alu setup b", b, io_out_b);
        run_to_halt("alu sub");
        check_word("alu sub", a - b, io_control);
        run_to_halt("alu and");
        check_word("alu and", a & b, io_control);
        run_to_halt("alu or");
        check_word("alu or", a | b, io_control);
        run_to_halt("alu xor");
        check_word("alu xor", a ^ b, io_control);
        run_to_halt("alu imm");
        check_word("alu addi", a + cpu_pkg::word_t'(k), io_out_a);
        check_word("alu subi", b - cpu_pkg::word_t'(k), io_out_b);
    end
endtask

task automatic flag_branches();
    cpu_pkg::opcode_e brs [4] = '{cpu_pkg::BZ, cpu_pkg::BNZ, cpu_pkg::BC, cpu_pkg::BNC};
    cpu_pkg::opcode_e fop;
    cpu_pkg::word_t   x;
    cpu_pkg::word_t   y;
    cpu_pkg::word_t   sum;
    logic             zf;
    logic             cf;
    for (int c = 0; c < 3; c++)
    begin
        x = lcg_next();
        case (c)
            0:
            begin
                y   = x;
                fop = cpu_pkg::CMP;
            end
            1:
            begin
                y   = lcg_next();
                fop = cpu_pkg::CMP;
            end
            default:
            begin
                // two's complement partner makes the sum wrap to zero
                y   = ~x + 16'd1;
                fop = cpu_pkg::ADD;
            end
        endcase
        if (fop == cpu_pkg::CMP)
        begin
            zf = (x == y);
            cf = (x < y);
        end
        else
        begin
            {cf, sum} = {1'b0, x} + {1'b0, y};
            zf = (sum == 16'h0000);
        end
        reset_cpu();
        load_const(2, x);
        load_const(3, y);
        alu_rrr(fop, 3, 2, 3);
        // r0 stays zero so the branch target is imm8 itself
        foreach (brs[i])
        begin
            emit_instr(cpu_pkg::SET, 1, 8'h00);
            emit_instr(brs[i], 0, prog_pc + 8'd2);
            // marker that a taken branch skips
            emit_instr(cpu_pkg::SET, 1, 8'hA5);
            emit_instr(cpu_pkg::HALT, 0, 8'h00);
        end
        foreach (brs[i])
        begin
            run_to_halt($sformatf("branch %s case %0d", brs[i].name(), c));
            check_word($sformatf("branch %s case %0d", brs[i].name(), c),
                       takes_branch(brs[i], zf, cf) ? 16'h0000 : 16'h00A5, io_control);
        end
    end
endtask

task automatic store_load();
    cpu_pkg::word_t w;
    cpu_pkg::word_t r;
    cpu_pkg::byte_t base;
    logic [3:0]     val;
    cpu_pkg::pc_t   addr;
    for (int round = 0; round < 2; round++)
    begin
        w    = lcg_next();
        r    = lcg_next();
        // data well above the program
        base = {2'b10, r[5:0]};
        val  = {1'b0, r[10:8]};
        addr = base + {4'h0, val};
        reset_cpu();
        load_const(1, w);
        emit_instr(cpu_pkg::SET, 2, base);
        emit_instr(cpu_pkg::SET, 3, 8'h00);
        mem_op(cpu_pkg::STORE, 1, 2, val);
        mem_op(cpu_pkg::LOAD, 3, 2, val);
        emit_instr(cpu_pkg::HALT, 0, 8'h00);
        run_to_halt("store load");
        check_byte("store low byte", w[7:0], mem[{addr, 1'b0}]);
        check_byte("store high byte", w[15:8], mem[{addr, 1'b1}]);
        check_word("load word", w, io_out_b);
    end
endtask

task automatic io_inputs();
    reset_cpu();
    io_data_a = lcg_next();
    io_data_b = lcg_next();
    io_status = lcg_next();
    emit_instr(cpu_pkg::LIOA, 1, 8'h00);
    emit_instr(cpu_pkg::LIOB, 2, 8'h00);
    emit_instr(cpu_pkg::LIOS, 3, 8'h00);
    emit_instr(cpu_pkg::HALT, 0, 8'h00);
    run_to_halt("io copy");
    check_word("lioa", io_data_a, io_control);
    check_word("liob", io_data_b, io_out_a);
    check_word("lios", io_status, io_out_b);
endtask

task automatic halt_resume();
    reset_cpu();
    check_flag("reset done", 1'b0, done);
    check_flag("reset d_we", 1'b0, d_we);
    emit_instr(cpu_pkg::NOP, 0, 8'h00);
    emit_instr(cpu_pkg::HALT, 0, 8'h00);
    // resume point jumps over the next word
    emit_instr(cpu_pkg::JUMP, 0, prog_pc + 8'd2);
    emit_instr(cpu_pkg::SET, 1, 8'h11);
    emit_instr(cpu_pkg::SET, 2, 8'h22);
    emit_instr(cpu_pkg::HALT, 0, 8'h00);
    run_to_halt("first halt");
    // sixteen idle cycles would cover the JUMP and the SET of r2
    repeat (16) @(posedge clk);
    #1;
    check_word("first halt", 16'h0000, io_out_a);
    run_to_halt("resume");
    check_word("jump skip", 16'h0000, io_control);
    check_word("resume after halt", 16'h0022, io_out_a);
endtask

`endif

// ==== tb/tb_serial_cpu.sv ====
/*
 * serial cpu testbench
 * shared byte memory model, LCG operands, typed compares and timeout
 */
`timescale 1ns/1ns
`include "cpu_cfg.svh"

module tb_serial_cpu;

    localparam int CLK_HALF = 4;
    // roughly 800 instructions of 7 cycles plus program loading
    localparam int TIMEOUT_CYCLES = 6000;
    localparam int MEM_BYTES = 2 ** (`CPU_PC_W + 1);

    logic               clk;
    logic               rst_n;
    logic               start;
    cpu_pkg::byte_t     i_datain;
    cpu_pkg::byte_t     d_datain;
    cpu_pkg::word_t     io_status;
    cpu_pkg::word_t     io_data_a;
    cpu_pkg::word_t     io_data_b;
    logic               is_i_addr;
    logic               done;
    logic               d_we;
    cpu_pkg::mem_addr_t i_addr;
    cpu_pkg::mem_addr_t d_addr;
    cpu_pkg::byte_t     d_dataout;
    cpu_pkg::word_t     io_control;
    cpu_pkg::word_t     io_out_a;
    cpu_pkg::word_t     io_out_b;

    // byte memory with one read port shared by fetch and data
    cpu_pkg::byte_t     mem [MEM_BYTES];
    cpu_pkg::byte_t     mem_rd;
    // program loader port writes one instruction word per cycle
    logic               ld_we;
    cpu_pkg::pc_t       ld_addr;
    cpu_pkg::word_t     ld_data;

    int                 cycles = 0;
    logic [31:0]        lcg_state = 32'd38;
    // next free word of the program being assembled
    cpu_pkg::pc_t       prog_pc;

    serial_cpu u_serial_cpu (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .i_datain   (i_datain),
        .d_datain   (d_datain),
        .io_status  (io_status),
        .io_data_a  (io_data_a),
        .io_data_b  (io_data_b),
        .is_i_addr  (is_i_addr),
        .done       (done),
        .d_we       (d_we),
        .i_addr     (i_addr),
        .d_addr     (d_addr),
        .d_dataout  (d_dataout),
        .io_control (io_control),
        .io_out_a   (io_out_a),
        .io_out_b   (io_out_b)
    );

    initial
    begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    // ------------------------------------------------------------------
    // memory model
    // ------------------------------------------------------------------
    assign mem_rd   = mem[is_i_addr ? i_addr : d_addr];
    assign i_datain = mem_rd;
    assign d_datain = mem_rd;

    always @(posedge clk)
    begin
        if (d_we)
            mem[d_addr] <= d_dataout;
        else if (ld_we)
        begin
            // low byte at the even address
            mem[{ld_addr, 1'b0}] <= ld_data[7:0];
            mem[{ld_addr, 1'b1}] <= ld_data[15:8];
        end
    end

    always @(posedge clk)
    begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES)
        begin
            $display("timeout: the cpu did not finish within %0d cycles", cycles);
            $display("Simulation finished: FAIL");
            $fatal(1, "run stopped by the cycle limit");
        end
    end

    // upper half of the lcg state has the better bits
    function automatic cpu_pkg::word_t lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[31:16];
    endfunction

    // ------------------------------------------------------------------
    // compares
    // ------------------------------------------------------------------
    task automatic check_word(string name, cpu_pkg::word_t exp, cpu_pkg::word_t act);
        if (exp !== act)
        begin
            $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
            $display("Simulation finished: FAIL");
            $fatal(1, "word compare");
        end
    endtask

    task automatic check_flag(string name, logic exp, logic act);
        if (exp !== act)
        begin
            $display("CHECK FAILED %s: expected %b, actual %b", name, exp, act);
            $display("Simulation finished: FAIL");
            $fatal(1, "flag compare");
        end
    endtask

    task automatic check_byte(string name, cpu_pkg::byte_t exp, cpu_pkg::byte_t act);
        if (exp !== act)
        begin
            $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
            $display("Simulation finished: FAIL");
            $fatal(1, "byte compare");
        end
    endtask

    // reset also puts the program origin back at the start pc
    task automatic reset_cpu();
        rst_n = 1'b0;
        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;
        prog_pc = cpu_pkg::pc_t'(`CPU_PC_START);
    endtask

    // pulse start and wait for the done cycle of the next halt
    task automatic run_to_halt(string name);
        int fetch_cyc;
        fetch_cyc = 0;
        start = 1'b1;
        @(posedge clk);
        #1;
        start = 1'b0;
        while (!done)
        begin
            // last low-byte fetch before done is the halt
            if (is_i_addr && !i_addr[0])
                fetch_cyc = cycles;
            @(posedge clk);
            #1;
        end
        check_word(name, 16'd7, cpu_pkg::word_t'(cycles - fetch_cyc));
        // no fetch follows a halt
        check_flag({name, " idle"}, 1'b0, is_i_addr);
        @(posedge clk);
        #1;
        check_flag(name, 1'b0, done);
    endtask

`include "cpu_tests.svh"

    initial
    begin
        rst_n     = 1'b0;
        start     = 1'b0;
        io_status = '0;
        io_data_a = '0;
        io_data_b = '0;
        ld_we     = 1'b0;
        ld_addr   = '0;
        ld_data   = '0;
        prog_pc   = '0;
        halt_resume();
        alu_ops();
        flag_branches();
        store_load();
        io_inputs();
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

// ==== project.f ====
+incdir+hdl
+incdir+tb
hdl/cpu_pkg.sv
hdl/cpu_sequencer.sv
hdl/operand_fetch.sv
hdl/exec_unit.sv
hdl/reg_file.sv
hdl/serial_cpu.sv
tb/tb_serial_cpu.sv

// ==== Makefile ====
# Verilator build and run for the serial cpu testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --assert -j 0
TOP       := tb_serial_cpu
FILELIST  := project.f
OBJDIR    := obj_dir
BIN       := $(OBJDIR)/V$(TOP)
SOURCES   := $(wildcard hdl/*.sv hdl/*.svh tb/*.sv tb/*.svh)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

# exit status of the simulator is the test result
run: compile
	./$(BIN)

clean:
	rm -rf $(OBJDIR)
